//--- hw/mem_unit_settings.svh
// Data width and opcode macros for the memory unit, included by RTL and testbench sources
`ifndef MEM_UNIT_SETTINGS_SVH
`define MEM_UNIT_SETTINGS_SVH

// address and data width
`define MU_XLEN 32

// RV32 major opcodes handled by the unit
`define MU_OPC_LOAD  7'b0000011
`define MU_OPC_STORE 7'b0100011

`endif

//--- hw/mem_unit_pkg.sv
// Shared types for the memory unit pipeline, imported by every stage and the top level
`default_nettype none

`include "mem_unit_settings.svh"

package mem_unit_pkg;

  // I-type layout, used by loads
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } load_view_s;

  // S-type layout, immediate split around rs2
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } store_view_s;

  typedef union packed {
    load_view_s  load_view;
    store_view_s store_view;
  } mem_insn_u;

  // encoding equals funct3 of the load
  typedef enum logic [2:0] {
    kind_lb  = 3'b000,
    kind_lh  = 3'b001,
    kind_lw  = 3'b010,
    kind_lbu = 3'b100,
    kind_lhu = 3'b101
  } load_kind_e;

  typedef struct packed {
    logic                is_load;
    logic                is_store;
    logic [`MU_XLEN-1:0] addr;
    logic [`MU_XLEN-1:0] wdata;
    logic [3:0]          wmask;
    load_kind_e          kind;
    logic [4:0]          rd;
  } mem_req_s;

  typedef struct packed {
    logic [`MU_XLEN-1:0] first;
    logic [`MU_XLEN-1:0] second;
    logic [1:0]          offset;
    load_kind_e          kind;
    logic [4:0]          rd;
    logic                is_load;
  } beat_data_s;

  typedef struct packed {
    logic [4:0]          rd;
    logic                reg_wen;
    logic [`MU_XLEN-1:0] value;
  } mem_result_s;

endpackage

`default_nettype wire

//--- hw/mem_decode.sv
// Decode stage of the memory unit, turns a load or store word into a registered request
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_settings.svh"

module mem_decode
  import mem_unit_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic                req_valid,
  input  mem_insn_u           insn,
  input  logic [`MU_XLEN-1:0] rs1_value,
  input  logic [`MU_XLEN-1:0] rs2_value,
  output logic                req_valid_q,
  output mem_req_s            req
);

  logic                is_load;
  logic                is_store;
  logic [2:0]          funct3;
  logic [`MU_XLEN-1:0] imm;
  logic [3:0]          wmask;
  load_kind_e          kind;

  // opcode and funct3 sit in the same bits in both views
  assign is_load  = insn.load_view.opcode == `MU_OPC_LOAD;
  assign is_store = insn.store_view.opcode == `MU_OPC_STORE;
  assign funct3   = insn.load_view.funct3;

  always_comb begin
    if (is_store) begin
      imm = {{(`MU_XLEN-12){insn.store_view.imm_hi[6]}},
             insn.store_view.imm_hi,
             insn.store_view.imm_lo};
    end else begin
      imm = {{(`MU_XLEN-12){insn.load_view.imm12[11]}},
             insn.load_view.imm12};
    end
  end

  // sb/sh/sw share the lb/lh/lw codes
  always_comb begin
    case (funct3)
      3'b000:  kind = kind_lb;
      3'b001:  kind = kind_lh;
      3'b100:  kind = kind_lbu;
      3'b101:  kind = kind_lhu;
      default: kind = kind_lw;
    endcase
    case (funct3[1:0])
      2'b00:   wmask = 4'b0001;
      2'b01:   wmask = 4'b0011;
      default: wmask = 4'b1111;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= req_valid && (is_load || is_store);
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid) begin
      req.is_load  <= is_load;
      req.is_store <= is_store;
      req.addr     <= rs1_value + imm;
      req.wdata    <= rs2_value;
      req.wmask    <= wmask;
      req.kind     <= kind;
      // stores have no destination
      req.rd       <= is_load ? insn.load_view.rd : 5'd0;
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_bus_master.sv
// Bus stage of the memory unit, runs loads and stores as AXI4-Lite beats and splits misaligned ones
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_settings.svh"

module lsu_bus_master
  import mem_unit_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic                req_valid_q,
  input  mem_req_s            req,
  // write address and data
  input  logic                awready,
  output logic                awvalid,
  output logic [`MU_XLEN-1:0] awaddr,
  input  logic                wready,
  output logic                wvalid,
  output logic [`MU_XLEN-1:0] wdata,
  output logic [3:0]          wstrb,
  // write response
  input  logic                bvalid,
  input  logic [1:0]          bresp,
  output logic                bready,
  // read address and data
  input  logic                arready,
  output logic                arvalid,
  output logic [`MU_XLEN-1:0] araddr,
  input  logic                rvalid,
  input  logic [1:0]          rresp,
  input  logic [`MU_XLEN-1:0] rdata,
  output logic                rready,
  // to the align stage
  output logic                beat_valid,
  output beat_data_s          beats
);

  // last is a single beat, first/mid are the two halves of a split
  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_last  = 2'b01,
    st_first = 2'b10,
    st_mid   = 2'b11
  } bus_state_e;

  bus_state_e            rd_state;
  bus_state_e            wr_state;
  logic [1:0]            offset;
  logic [`MU_XLEN-1:0]   word_addr;
  logic [7:0]            strb_pair;
  logic [2*`MU_XLEN-1:0] data_pair;
  logic [`MU_XLEN-1:0]   data_rot;
  logic [3:0]            strb_hi;
  logic [2:0]            load_bytes;
  logic                  rd_split;
  logic                  wr_split;
  logic                  rd_start;
  logic                  wr_start;
  logic                  rd_done;
  logic                  wr_done;

  assign offset    = req.addr[1:0];
  assign word_addr = {req.addr[`MU_XLEN-1:2], 2'b00};
  assign rd_start  = req_valid_q && req.is_load;
  assign wr_start  = req_valid_q && req.is_store;

  // mask and data moved onto the lanes of the target word
  assign strb_pair = {4'b0000, req.wmask} << offset;
  assign data_pair = {{`MU_XLEN{1'b0}}, req.wdata} << {offset, 3'b000};
  assign data_rot  = data_pair[`MU_XLEN-1:0] | data_pair[2*`MU_XLEN-1:`MU_XLEN];
  // spilled strobes go to the next word
  assign wr_split  = |strb_pair[7:4];

  always_comb begin
    case (req.kind)
      kind_lb, kind_lbu: load_bytes = 3'd1;
      kind_lh, kind_lhu: load_bytes = 3'd2;
      default:           load_bytes = 3'd4;
    endcase
  end

  assign rd_split = ({1'b0, offset} + load_bytes) > 3'd4;

  // read FSM
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state <= st_idle;
      arvalid  <= 1'b0;
    end else begin
      case (rd_state)
        st_idle: begin
          if (rd_start) begin
            arvalid  <= 1'b1;
            rd_state <= rd_split ? st_first : st_last;
          end
        end
        st_first: begin
          if (arvalid && arready) arvalid <= 1'b0;
          // lower word is back, ask for the next one at once
          if (rvalid) begin
            arvalid  <= 1'b1;
            rd_state <= st_mid;
          end
        end
        default: begin
          if (arvalid && arready) arvalid <= 1'b0;
          if (rvalid) rd_state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (rd_start) begin
      araddr <= word_addr;
    end else if (rd_state == st_first && rvalid) begin
      araddr <= araddr + `MU_XLEN'(4);
    end
  end

  // write FSM, aw and w drop on their own handshakes
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_state <= st_idle;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
    end else begin
      case (wr_state)
        st_idle: begin
          if (wr_start) begin
            awvalid  <= 1'b1;
            wvalid   <= 1'b1;
            wr_state <= wr_split ? st_first : st_last;
          end
        end
        st_first: begin
          if (awvalid && awready) awvalid <= 1'b0;
          if (wvalid && wready) wvalid <= 1'b0;
          if (bvalid) begin
            awvalid  <= 1'b1;
            wvalid   <= 1'b1;
            wr_state <= st_mid;
          end
        end
        default: begin
          if (awvalid && awready) awvalid <= 1'b0;
          if (wvalid && wready) wvalid <= 1'b0;
          if (bvalid) wr_state <= st_idle;
        end
      endcase
    end
  end

  // rotated data serves both beats, only the strobes change
  always_ff @(posedge clock) begin
    if (wr_start) begin
      awaddr  <= word_addr;
      wdata   <= data_rot;
      wstrb   <= strb_pair[3:0];
      strb_hi <= strb_pair[7:4];
    end else if (wr_state == st_first && bvalid) begin
      awaddr <= awaddr + `MU_XLEN'(4);
      wstrb  <= strb_hi;
    end
  end

  assign rd_done = rvalid && (rd_state == st_last || rd_state == st_mid);
  assign wr_done = bvalid && (wr_state == st_last || wr_state == st_mid);

  always_ff @(posedge clock) begin
    if (reset) begin
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= rd_done || wr_done;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid_q) begin
      beats.offset  <= offset;
      beats.kind    <= req.kind;
      beats.rd      <= req.rd;
      beats.is_load <= req.is_load;
      beats.second  <= '0;
    end
    if (rvalid) begin
      if (rd_state == st_mid) begin
        beats.second <= rdata;
      end else if (rd_state != st_idle) begin
        beats.first <= rdata;
      end
    end
  end

  assign rready = 1'b1;
  assign bready = 1'b1;

endmodule

`default_nettype wire

//--- hw/load_align.sv
// Align stage of the memory unit, picks the load bytes out of the read beats and extends them
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_settings.svh"

module load_align
  import mem_unit_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        beat_valid,
  input  beat_data_s  beats,
  output logic        result_valid,
  output mem_result_s result
);

  logic [2*`MU_XLEN-1:0] pair_shift;
  logic [`MU_XLEN-1:0]   aligned;
  logic [`MU_XLEN-1:0]   extended;

  // upper word supplies the bytes past lane 3
  assign pair_shift = {beats.second, beats.first} >> {beats.offset, 3'b000};
  assign aligned    = pair_shift[`MU_XLEN-1:0];

  always_comb begin
    case (beats.kind)
      kind_lb:  extended = {{(`MU_XLEN-8){aligned[7]}}, aligned[7:0]};
      kind_lh:  extended = {{(`MU_XLEN-16){aligned[15]}}, aligned[15:0]};
      kind_lbu: extended = {{(`MU_XLEN-8){1'b0}}, aligned[7:0]};
      kind_lhu: extended = {{(`MU_XLEN-16){1'b0}}, aligned[15:0]};
      default:  extended = aligned;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= beat_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (beat_valid) begin
      result.rd      <= beats.rd;
      result.reg_wen <= beats.is_load;
      // stores report zero
      result.value   <= beats.is_load ? extended : '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/mem_unit_top.sv
// Top level of the memory unit, chains decode, bus master and align stages behind one AXI4-Lite port
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_settings.svh"

module mem_unit_top
  import mem_unit_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic                req_valid,
  input  mem_insn_u           insn,
  input  logic [`MU_XLEN-1:0] rs1_value,
  input  logic [`MU_XLEN-1:0] rs2_value,
  output logic                result_valid,
  output mem_result_s         result,
  input  logic                awready,
  output logic                awvalid,
  output logic [`MU_XLEN-1:0] awaddr,
  input  logic                wready,
  output logic                wvalid,
  output logic [`MU_XLEN-1:0] wdata,
  output logic [3:0]          wstrb,
  input  logic                bvalid,
  input  logic [1:0]          bresp,
  output logic                bready,
  input  logic                arready,
  output logic                arvalid,
  output logic [`MU_XLEN-1:0] araddr,
  input  logic                rvalid,
  input  logic [1:0]          rresp,
  input  logic [`MU_XLEN-1:0] rdata,
  output logic                rready
);

  logic       req_valid_q;
  mem_req_s   req;
  logic       beat_valid;
  beat_data_s beats;

  mem_decode u_decode (
    .clock, .reset, .req_valid, .insn, .rs1_value, .rs2_value, .req_valid_q, .req
  );

  lsu_bus_master u_bus (
    .clock, .reset, .req_valid_q, .req,
    .awready, .awvalid, .awaddr, .wready, .wvalid, .wdata, .wstrb,
    .bvalid, .bresp, .bready,
    .arready, .arvalid, .araddr, .rvalid, .rresp, .rdata, .rready,
    .beat_valid, .beats
  );

  load_align u_align (
    .clock, .reset, .beat_valid, .beats, .result_valid, .result
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// Free-running clock for the memory unit testbench, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real period_ns = 20.0
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2.0) clock = ~clock;
  end

endmodule

`default_nettype wire

//--- testbench/axi_lite_mem.sv
// Behavioral AXI4-Lite slave with a 1 KiB byte array and random ready and response delays
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_settings.svh"

module axi_lite_mem (
  input  logic                clock,
  input  logic                reset,
  input  logic                awvalid,
  input  logic [`MU_XLEN-1:0] awaddr,
  output logic                awready,
  input  logic                wvalid,
  input  logic [`MU_XLEN-1:0] wdata,
  input  logic [3:0]          wstrb,
  output logic                wready,
  output logic                bvalid,
  output logic [1:0]          bresp,
  input  logic                bready,
  input  logic                arvalid,
  input  logic [`MU_XLEN-1:0] araddr,
  output logic                arready,
  output logic                rvalid,
  output logic [1:0]          rresp,
  output logic [`MU_XLEN-1:0] rdata,
  input  logic                rready
);

  logic [7:0]          bytes [0:1023];
  // completed transfers and the addresses of the last two
  int unsigned         xfer_count;
  logic [`MU_XLEN-1:0] prev_addr;
  logic [`MU_XLEN-1:0] last_addr;
  logic                aw_got;
  logic                w_got;
  logic                ar_got;
  logic [`MU_XLEN-1:0] wr_addr;
  logic [`MU_XLEN-1:0] wr_data;
  logic [3:0]          wr_strb;
  logic [`MU_XLEN-1:0] rd_addr;
  int unsigned         aw_delay;
  int unsigned         w_delay;
  int unsigned         b_delay;
  int unsigned         ar_delay;
  int unsigned         r_delay;

  // every address bit shows up in the pattern
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'((a * 7) ^ (a >> 3));
  endfunction

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  initial begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
  end

  always @(posedge clock) begin
    if (reset) begin
      awready    <= 1'b0;
      wready     <= 1'b0;
      bvalid     <= 1'b0;
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
      ar_got     <= 1'b0;
      aw_delay   <= 0;
      w_delay    <= 0;
      b_delay    <= 0;
      ar_delay   <= 0;
      r_delay    <= 0;
      xfer_count <= 0;
      prev_addr  <= '0;
      last_addr  <= '0;
      for (int i = 0; i < 1024; i++) begin
        bytes[i] <= fill_byte(i);
      end
    end else begin
      // write address channel
      if (awready) begin
        awready  <= 1'b0;
        aw_got   <= 1'b1;
        wr_addr  <= awaddr;
        aw_delay <= $urandom % 4;
      end else if (awvalid && !aw_got) begin
        if (aw_delay == 0) awready <= 1'b1;
        else aw_delay <= aw_delay - 1;
      end
      // write data channel
      if (wready) begin
        wready  <= 1'b0;
        w_got   <= 1'b1;
        wr_data <= wdata;
        wr_strb <= wstrb;
        w_delay <= $urandom % 4;
      end else if (wvalid && !w_got) begin
        if (w_delay == 0) wready <= 1'b1;
        else w_delay <= w_delay - 1;
      end
      // response once both halves are in, held until bready
      if (bvalid) begin
        if (bready) begin
          bvalid  <= 1'b0;
          aw_got  <= 1'b0;
          w_got   <= 1'b0;
          b_delay <= $urandom % 4;
        end
      end else if (aw_got && w_got) begin
        if (b_delay == 0) begin
          bvalid <= 1'b1;
          for (int k = 0; k < 4; k++) begin
            if (wr_strb[k]) bytes[{wr_addr[9:2], 2'(k)}] <= wr_data[8*k +: 8];
          end
        end else begin
          b_delay <= b_delay - 1;
        end
      end
      // read address channel
      if (arready) begin
        arready  <= 1'b0;
        ar_got   <= 1'b1;
        rd_addr  <= araddr;
        ar_delay <= $urandom % 4;
      end else if (arvalid && !ar_got) begin
        if (ar_delay == 0) arready <= 1'b1;
        else ar_delay <= ar_delay - 1;
      end
      if (rvalid) begin
        if (rready) begin
          rvalid  <= 1'b0;
          ar_got  <= 1'b0;
          r_delay <= $urandom % 4;
        end
      end else if (ar_got) begin
        if (r_delay == 0) begin
          rvalid <= 1'b1;
          rdata  <= {bytes[{rd_addr[9:2], 2'd3}], bytes[{rd_addr[9:2], 2'd2}],
                     bytes[{rd_addr[9:2], 2'd1}], bytes[{rd_addr[9:2], 2'd0}]};
        end else begin
          r_delay <= r_delay - 1;
        end
      end
      // log each finished transfer
      if ((bvalid && bready) || (rvalid && rready)) begin
        xfer_count <= xfer_count + 1;
        prev_addr  <= last_addr;
        last_addr  <= bvalid ? wr_addr : rd_addr;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/mem_unit_chk.sv
// Protocol assertions on the AXI4-Lite port and result pulse, bound into the memory unit top level
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_settings.svh"

module mem_unit_chk (
  input logic                clock,
  input logic                reset,
  input logic                awvalid,
  input logic                awready,
  input logic [`MU_XLEN-1:0] awaddr,
  input logic                wvalid,
  input logic                wready,
  input logic [`MU_XLEN-1:0] wdata,
  input logic [3:0]          wstrb,
  input logic                bvalid,
  input logic                arvalid,
  input logic                arready,
  input logic [`MU_XLEN-1:0] araddr,
  input logic                rvalid,
  input logic                result_valid
);

  // set from a raised valid until its response comes back
  logic ar_open;
  logic aw_open;

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_open <= 1'b0;
      aw_open <= 1'b0;
    end else begin
      if (rvalid) ar_open <= 1'b0;
      else if (arvalid) ar_open <= 1'b1;
      if (bvalid) aw_open <= 1'b0;
      else if (awvalid) aw_open <= 1'b1;
    end
  end

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid or awaddr changed before awready");

  w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else $error("wvalid, wdata or wstrb changed before wready");

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid or araddr changed before arready");

  addr_aligned: assert property (@(posedge clock) disable iff (reset)
    (!awvalid || awaddr[1:0] == 2'b00) && (!arvalid || araddr[1:0] == 2'b00))
    else $error("bus address is not word aligned");

  result_pulse: assert property (@(posedge clock) disable iff (reset)
    result_valid |=> !result_valid)
    else $error("result_valid held for more than one cycle");

  ar_single: assert property (@(posedge clock) disable iff (reset)
    $rose(arvalid) |-> !ar_open)
    else $error("arvalid rose again before the previous read completed");

  aw_single: assert property (@(posedge clock) disable iff (reset)
    $rose(awvalid) |-> !aw_open)
    else $error("awvalid rose again before the previous write completed");

endmodule

bind mem_unit_top mem_unit_chk chk (
  .clock        (clock),
  .reset        (reset),
  .awvalid      (awvalid),
  .awready      (awready),
  .awaddr       (awaddr),
  .wvalid       (wvalid),
  .wready       (wready),
  .wdata        (wdata),
  .wstrb        (wstrb),
  .bvalid       (bvalid),
  .arvalid      (arvalid),
  .arready      (arready),
  .araddr       (araddr),
  .rvalid       (rvalid),
  .result_valid (result_valid)
);

`default_nettype wire

//--- testbench/mem_unit_tb.sv
// Testbench for the memory unit, runs directed and random loads and stores against a shadow memory
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_settings.svh"

module mem_unit_tb
  import mem_unit_pkg::*;
();

  localparam int num_random   = 200;
  localparam int num_directed = 27;
  localparam int cycle_limit  = 200 * (num_random + num_directed);

  localparam logic [2:0] f_b  = 3'b000;
  localparam logic [2:0] f_h  = 3'b001;
  localparam logic [2:0] f_w  = 3'b010;
  localparam logic [2:0] f_bu = 3'b100;
  localparam logic [2:0] f_hu = 3'b101;

  logic                clock;
  logic                reset;
  logic                req_valid;
  mem_insn_u           insn;
  logic [`MU_XLEN-1:0] rs1_value;
  logic [`MU_XLEN-1:0] rs2_value;
  logic                result_valid;
  mem_result_s         result;
  logic                awvalid;
  logic                awready;
  logic [`MU_XLEN-1:0] awaddr;
  logic                wvalid;
  logic                wready;
  logic [`MU_XLEN-1:0] wdata;
  logic [3:0]          wstrb;
  logic                bvalid;
  logic [1:0]          bresp;
  logic                bready;
  logic                arvalid;
  logic                arready;
  logic [`MU_XLEN-1:0] araddr;
  logic                rvalid;
  logic [1:0]          rresp;
  logic [`MU_XLEN-1:0] rdata;
  logic                rready;

  logic [7:0]          shadow [0:1023];
  mem_result_s         expect_q[$];
  string               name_q[$];
  int unsigned         results_seen;
  int unsigned         cycle_count;

  tb_clock clock_gen (.clock);

  mem_unit_top dut (
    .clock, .reset, .req_valid, .insn, .rs1_value, .rs2_value, .result_valid, .result,
    .awready, .awvalid, .awaddr, .wready, .wvalid, .wdata, .wstrb,
    .bvalid, .bresp, .bready,
    .arready, .arvalid, .araddr, .rvalid, .rresp, .rdata, .rready
  );

  axi_lite_mem mem_model (
    .clock, .reset, .awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready, .arvalid, .araddr, .arready, .rvalid, .rresp, .rdata, .rready
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic int access_size(input logic [2:0] funct3);
    case (funct3[1:0])
      2'b00:   return 1;
      2'b01:   return 2;
      default: return 4;
    endcase
  endfunction

  // little-endian read of the shadow, then extension by funct3
  function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [2:0] funct3);
    logic [31:0] raw;
    raw = '0;
    for (int k = 0; k < 4; k++) begin
      raw[8*k +: 8] = shadow[10'(addr + 32'(k))];
    end
    case (funct3)
      f_b:     return {{24{raw[7]}}, raw[7:0]};
      f_h:     return {{16{raw[15]}}, raw[15:0]};
      f_bu:    return {24'd0, raw[7:0]};
      f_hu:    return {16'd0, raw[15:0]};
      default: return raw;
    endcase
  endfunction

  function automatic void shadow_store(input logic [31:0] addr, input logic [31:0] data,
                                       input logic [2:0] funct3);
    for (int k = 0; k < access_size(funct3); k++) begin
      shadow[10'(addr + 32'(k))] = data[8*k +: 8];
    end
  endfunction

  // one request with a random immediate, then wait for its result
  task automatic run_access(input string name, input logic store, input logic [2:0] funct3,
                            input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] word;
    logic [11:0] imm;
    logic [4:0]  rd;
    mem_result_s expected;
    int unsigned sent;
    int unsigned split;
    int unsigned xfers_before;
    imm = 12'($urandom);
    rd  = 5'($urandom % 31 + 1);
    if (store) begin
      word     = {imm[11:5], 5'd2, 5'd1, funct3, imm[4:0], `MU_OPC_STORE};
      expected = '{rd: 5'd0, reg_wen: 1'b0, value: 32'd0};
    end else begin
      word     = {imm, 5'd1, funct3, rd, `MU_OPC_LOAD};
      expected = '{rd: rd, reg_wen: 1'b1, value: ref_load(addr, funct3)};
    end
    split = (int'(addr[1:0]) + access_size(funct3) > 4) ? 2 : 1;
    expect_q.push_back(expected);
    name_q.push_back(name);
    sent         = results_seen + 1;
    xfers_before = mem_model.xfer_count;
    @(posedge clock);
    req_valid <= 1'b1;
    insn      <= word;
    rs1_value <= addr - {{20{imm[11]}}, imm};
    rs2_value <= data;
    @(posedge clock);
    req_valid <= 1'b0;
    while (results_seen < sent) @(posedge clock);
    if (store) shadow_store(addr, data, funct3);
    assert (mem_model.xfer_count - xfers_before == split)
      else fail_run($sformatf("[FAIL] %s: expected %0d transfers, actual %0d", name, split,
                              mem_model.xfer_count - xfers_before));
    if (split == 2) begin
      assert (mem_model.prev_addr == {addr[31:2], 2'b00} &&
              mem_model.last_addr == mem_model.prev_addr + 32'd4)
        else fail_run($sformatf("[FAIL] %s: expected words %h and %h, actual %h and %h", name,
                                {addr[31:2], 2'b00}, {addr[31:2], 2'b00} + 32'd4,
                                mem_model.prev_addr, mem_model.last_addr));
    end
  endtask

  // compare every result pulse with the oldest expectation
  always @(posedge clock) begin
    mem_result_s expected;
    string       name;
    if (reset) begin
      results_seen <= 0;
    end else if (result_valid) begin
      assert (expect_q.size() > 0)
        else fail_run("result pulse arrived with no request outstanding");
      expected = expect_q.pop_front();
      name     = name_q.pop_front();
      assert (result == expected)
        else fail_run($sformatf(
          "[FAIL] %s: expected rd=%0d wen=%0b value=%h, actual rd=%0d wen=%0b value=%h",
          name, expected.rd, expected.reg_wen, expected.value,
          result.rd, result.reg_wen, result.value));
      results_seen <= results_seen + 1;
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        fail_run($sformatf("run timed out after %0d cycles", cycle_count));
      end
    end
  end

  initial begin
    int unsigned seen_before;
    int unsigned pick;
    logic        rstore;
    logic [2:0]  rf3;
    void'($urandom(91536));
    reset     = 1'b1;
    req_valid = 1'b0;
    insn      = '0;
    rs1_value = '0;
    rs2_value = '0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = mem_model.bytes[i];
    end
    assert (!result_valid && !arvalid && !awvalid && !wvalid && rready && bready)
      else fail_run("a valid or ready output has the wrong level after reset");

    // aligned loads on the preloaded pattern
    run_access("lw aligned", 1'b0, f_w, 32'h40, 32'd0);
    run_access("lh aligned", 1'b0, f_h, 32'h42, 32'd0);
    run_access("lhu aligned", 1'b0, f_hu, 32'h42, 32'd0);
    for (int k = 0; k < 4; k++) begin
      run_access("lb aligned", 1'b0, f_b, 32'h44 + 32'(k), 32'd0);
      run_access("lbu aligned", 1'b0, f_bu, 32'h44 + 32'(k), 32'd0);
    end

    // aligned stores merged into one word
    run_access("sw aligned", 1'b1, f_w, 32'h80, 32'hdeadbeef);
    run_access("sh aligned", 1'b1, f_h, 32'h82, 32'h1234a5f0);
    run_access("sb aligned", 1'b1, f_b, 32'h81, 32'h0000007e);
    run_access("lw after stores", 1'b0, f_w, 32'h80, 32'd0);
    run_access("lw next word", 1'b0, f_w, 32'h84, 32'd0);

    // accesses that cross a word boundary
    for (int k = 1; k < 4; k++) begin
      run_access("sw misaligned", 1'b1, f_w, 32'h100 + 32'(9 * k), $urandom);
      run_access("lw misaligned", 1'b0, f_w, 32'h100 + 32'(9 * k), 32'd0);
    end
    run_access("sh offset 3", 1'b1, f_h, 32'h133, 32'h0000c3a1);
    run_access("lh offset 3", 1'b0, f_h, 32'h133, 32'd0);
    run_access("lhu offset 3", 1'b0, f_hu, 32'h143, 32'd0);

    // an R-type word is dropped by the decoder
    seen_before = results_seen;
    @(posedge clock);
    req_valid <= 1'b1;
    insn      <= 32'h002081b3;
    @(posedge clock);
    req_valid <= 1'b0;
    repeat (20) @(posedge clock);
    assert (results_seen == seen_before)
      else fail_run("a non-memory instruction produced a result pulse");
    run_access("lw after dropped word", 1'b0, f_w, 32'h40, 32'd0);

    for (int n = 0; n < num_random; n++) begin
      rstore = 1'($urandom);
      pick   = $urandom % 5;
      case (pick)
        0:       rf3 = f_b;
        1:       rf3 = f_h;
        2:       rf3 = f_w;
        3:       rf3 = f_bu;
        default: rf3 = f_hu;
      endcase
      // stores have no unsigned forms
      if (rstore) rf3[2] = 1'b0;
      run_access(rstore ? "random store" : "random load", rstore, rf3,
                 32'($urandom % 1020), $urandom);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/mem_unit_pkg.sv
hw/mem_decode.sv
hw/lsu_bus_master.sv
hw/load_align.sv
hw/mem_unit_top.sv
testbench/tb_clock.sv
testbench/axi_lite_mem.sv
testbench/mem_unit_chk.sv
testbench/mem_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory unit testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mem_unit_tb -f tb.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vmem_unit_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
